// ==== list.f ====
+incdir+verilog
verilog/cfg_loader_pkg.sv
verilog/prog_word_filter.sv
verilog/cfg_slot_sequencer.sv
verilog/cfg_field_assembler.sv
verilog/cfg_record_fifo.sv
verilog/cfg_loader_top.sv
sim/tb_clock_gen.sv
sim/tb_cfg_loader.sv

// ==== Bender.yml ====
package:
  name: cfg_loader

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cfg_loader_pkg.sv
      - verilog/prog_word_filter.sv
      - verilog/cfg_slot_sequencer.sv
      - verilog/cfg_field_assembler.sv
      - verilog/cfg_record_fifo.sv
      - verilog/cfg_loader_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_cfg_loader.sv

// ==== sim/tb_cfg_loader.sv ====
// ---------------------------------------------------------------------------
// Configuration loader testbench: directed tests, reference record model,
// compare tasks and watchdog
// ---------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "cfg_loader_defs.svh"

module tb_cfg_loader;

    localparam int unsigned SLOT_BASE = 16;
    localparam int NUM_TESTS = 5;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 400 + 18 * `CFG_SLOT_COUNT;

    logic                        ap_clk;
    logic                        arst_n;
    logic                        word_valid;
    cfg_loader_pkg::mem_cmd_e    word_cmd;
    logic [`CFG_ADDR_W-1:0]      word_offset;
    logic [`CFG_SHIFT_W-1:0]     word_shift;
    logic [`CFG_DATA_W-1:0]      word_data;
    logic                        cfg_pop;
    logic                        cfg_valid;
    cfg_loader_pkg::cfg_record_t cfg_record;
    logic                        cfg_full;
    logic                        cfg_empty;

    // Reference record and records expected out of the FIFO
    cfg_loader_pkg::cfg_record_t ref_rec;
    cfg_loader_pkg::cfg_record_t exp_q[$];
    integer                      seed;
    int                          error_count;

    tb_clock_gen #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (3)
    ) u_clock_gen (
        .ap_clk (ap_clk),
        .arst_n (arst_n)
    );

    cfg_loader_top #(
        .SLOT_BASE (SLOT_BASE)
    ) DUT (
        .ap_clk      (ap_clk),
        .arst_n      (arst_n),
        .word_valid  (word_valid),
        .word_cmd    (word_cmd),
        .word_offset (word_offset),
        .word_shift  (word_shift),
        .word_data   (word_data),
        .cfg_pop     (cfg_pop),
        .cfg_valid   (cfg_valid),
        .cfg_record  (cfg_record),
        .cfg_full    (cfg_full),
        .cfg_empty   (cfg_empty)
    );

    // -----------------------------------------------------------------------
    // Error handling and compare tasks
    // -----------------------------------------------------------------------
    task automatic fail_run(input string msg);
        error_count++;
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic compare_record(input cfg_loader_pkg::cfg_record_t actual,
                                  input cfg_loader_pkg::cfg_record_t expected,
                                  input string what);
        if (actual !== expected) begin
            fail_run($sformatf("MISMATCH at %0t ns: %s got %h expected %h",
                               $time, what, actual, expected));
        end
    endtask

    task automatic compare_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            fail_run($sformatf("MISMATCH at %0t ns: %s got %b expected %b",
                               $time, what, actual, expected));
        end
    endtask

    // Slot layout of the record
    task automatic update_reference(input cfg_loader_pkg::slot_t slot,
                                    input logic [31:0] data);
        case (slot)
            4'd0: ref_rec.filter_op = cfg_loader_pkg::filter_op_e'(data[2:0]);
            4'd1: ref_rec.filter_mask = data[3:0];
            4'd2: ref_rec.const_mask = data[3:0];
            4'd3: ref_rec.const_value = data;
            4'd4: ref_rec.ops_mask = data[15:0];
            4'd5: ref_rec.flags = {data[0], data[1], data[2], data[3], data[4], data[5], data[6]};
            4'd6: begin
                ref_rec.route_if.cu     = data[3:0];
                ref_rec.route_if.bundle = data[7:4];
                ref_rec.route_if.lane   = data[11:8];
            end
            4'd7: begin
                ref_rec.route_else.cu     = data[3:0];
                ref_rec.route_else.bundle = data[7:4];
                ref_rec.route_else.lane   = data[11:8];
            end
            4'd8: begin
                ref_rec.route_if.engine      = data[3:0];
                ref_rec.route_if.module_id   = data[7:4];
                ref_rec.route_else.engine    = data[11:8];
                ref_rec.route_else.module_id = data[15:12];
            end
            default: begin
            end
        endcase
    endtask

    // -----------------------------------------------------------------------
    // Stimulus, all driven on the falling edge
    // -----------------------------------------------------------------------
    task automatic send_word(input cfg_loader_pkg::mem_cmd_e cmd, input int unsigned index,
                             input logic [`CFG_SHIFT_W-1:0] shift, input logic [31:0] data);
        @(negedge ap_clk);
        word_valid  = 1'b1;
        word_cmd    = cmd;
        word_offset = 32'(index) << shift;
        word_shift  = shift;
        word_data   = data;
        if (cmd == cfg_loader_pkg::CMD_MEM_PROGRAM && index >= SLOT_BASE &&
            index < SLOT_BASE + `CFG_SLOT_COUNT) begin
            update_reference(cfg_loader_pkg::slot_t'(index - SLOT_BASE), data);
        end
    endtask

    task automatic drive_idle();
        @(negedge ap_clk);
        word_valid = 1'b0;
        word_cmd   = cfg_loader_pkg::CMD_INVALID;
    endtask

    // Slots 0 to 15 in order, optionally mixed with words that must be ignored
    task automatic send_sequence(input logic [`CFG_SHIFT_W-1:0] shift, input bit with_noise);
        for (int slot = 0; slot < `CFG_SLOT_COUNT; slot++) begin
            send_word(cfg_loader_pkg::CMD_MEM_PROGRAM, SLOT_BASE + slot, shift, $random(seed));
            if (with_noise) begin
                send_word(cfg_loader_pkg::CMD_MEM_PROGRAM, SLOT_BASE - 1, shift, $random(seed));
                send_word(cfg_loader_pkg::CMD_MEM_PROGRAM, SLOT_BASE + 16, shift, $random(seed));
                send_word(cfg_loader_pkg::CMD_MEM_READ, SLOT_BASE + slot, shift, $random(seed));
            end
        end
        drive_idle();
        // A record arriving at a full FIFO is dropped
        if (exp_q.size() < `CFG_FIFO_DEPTH) begin
            exp_q.push_back(ref_rec);
        end
    endtask

    // Record reaches the FIFO a fixed 3 cycles after its last word
    task automatic settle_write();
        repeat (3) @(negedge ap_clk);
    endtask

    task automatic wait_not_empty();
        int n;
        n = 0;
        while (cfg_empty && n < 40) begin
            @(negedge ap_clk);
            n++;
        end
        if (cfg_empty) begin
            fail_run("cfg_empty did not fall after a complete sequence");
        end
    endtask

    task automatic pop_expected();
        cfg_loader_pkg::cfg_record_t expected;
        if (exp_q.size() == 0) begin
            fail_run("pop requested while no record is expected");
        end
        expected = exp_q.pop_front();
        @(negedge ap_clk);
        cfg_pop = 1'b1;
        @(negedge ap_clk);
        cfg_pop = 1'b0;
        if (!cfg_valid) begin
            fail_run("no cfg_valid pulse one cycle after a pop");
        end
        compare_record(cfg_record, expected, "popped record");
        @(negedge ap_clk);
        compare_flag(cfg_valid, 1'b0, "cfg_valid one cycle after pulse");
        compare_record(cfg_record, expected, "cfg_record held after pulse");
    endtask

    task automatic pop_while_empty();
        compare_flag(cfg_empty, 1'b1, "cfg_empty before empty pop");
        @(negedge ap_clk);
        cfg_pop = 1'b1;
        @(negedge ap_clk);
        cfg_pop = 1'b0;
        repeat (4) begin
            compare_flag(cfg_valid, 1'b0, "cfg_valid after pop while empty");
            @(negedge ap_clk);
        end
    endtask

    // -----------------------------------------------------------------------
    // Directed tests
    // -----------------------------------------------------------------------
    task automatic test_full_load();
        $display("Test 1: full load");
        send_sequence(5'd2, 1'b0);
        wait_not_empty();
        pop_expected();
        compare_flag(cfg_empty, 1'b1, "cfg_empty after full load pop");
    endtask

    task automatic test_filtering();
        $display("Test 2: filtering");
        send_sequence(5'd3, 1'b1);
        wait_not_empty();
        pop_expected();
    endtask

    task automatic test_start_rule();
        $display("Test 3: start rule");
        // Stray slot 5, then slots 1 to 15 that would close a sequence opened by it
        send_word(cfg_loader_pkg::CMD_MEM_PROGRAM, SLOT_BASE + 5, 5'd0, $random(seed));
        for (int slot = 1; slot < `CFG_SLOT_COUNT; slot++) begin
            send_word(cfg_loader_pkg::CMD_MEM_PROGRAM, SLOT_BASE + slot, 5'd0, $random(seed));
        end
        drive_idle();
        repeat (20) begin
            @(negedge ap_clk);
            compare_flag(cfg_empty, 1'b1, "cfg_empty after stray slot 5 word");
        end
        send_sequence(5'd0, 1'b0);
        wait_not_empty();
        pop_expected();
    endtask

    task automatic test_ordering();
        $display("Test 4: ordering and retention");
        send_sequence(5'd2, 1'b0);
        send_sequence(5'd4, 1'b0);
        settle_write();
        pop_expected();
        pop_expected();
        compare_flag(cfg_empty, 1'b1, "cfg_empty after two pops");
    endtask

    task automatic test_full_empty();
        $display("Test 5: full and empty");
        compare_flag(cfg_empty, 1'b1, "cfg_empty before fill");
        repeat (`CFG_FIFO_DEPTH) send_sequence(5'd2, 1'b0);
        settle_write();
        compare_flag(cfg_full, 1'b1, "cfg_full after 16 records");
        send_sequence(5'd2, 1'b0);
        settle_write();
        compare_flag(cfg_full, 1'b1, "cfg_full after dropped record");
        repeat (`CFG_FIFO_DEPTH) pop_expected();
        pop_while_empty();
        compare_flag(cfg_empty, 1'b1, "cfg_empty at end");
        compare_flag(cfg_full, 1'b0, "cfg_full at end");
    endtask

    // -----------------------------------------------------------------------
    // Main sequence and watchdog
    // -----------------------------------------------------------------------
    initial begin
        seed        = 32'h6a97_2771;
        error_count = 0;
        ref_rec     = '0;
        word_valid  = 1'b0;
        word_cmd    = cfg_loader_pkg::CMD_INVALID;
        word_offset = '0;
        word_shift  = '0;
        word_data   = '0;
        cfg_pop     = 1'b0;
        wait (arst_n === 1'b1);
        @(negedge ap_clk);
        compare_flag(cfg_empty, 1'b1, "cfg_empty after reset");
        compare_flag(cfg_full, 1'b0, "cfg_full after reset");
        compare_flag(cfg_valid, 1'b0, "cfg_valid after reset");
        compare_record(cfg_record, '0, "cfg_record after reset");
        test_full_load();
        test_filtering();
        test_start_rule();
        test_ordering();
        test_full_empty();
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge ap_clk);
        fail_run($sformatf("Timeout: tests did not finish within %0d clock cycles",
                           WATCHDOG_CYCLES));
    end

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
// ---------------------------------------------------------------------------
// Testbench clock and active-low reset generator
// ---------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic ap_clk,
    output logic arst_n
);

    initial begin
        ap_clk = 1'b0;
        forever #(PERIOD_NS / 2) ap_clk = ~ap_clk;
    end

    // Release away from the rising edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge ap_clk);
        @(negedge ap_clk);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verilog/cfg_loader_top.sv ====
// -------------------------------------------------------------------------
// Configuration loader top: filter, sequencer, assembler and record FIFO
// -------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "cfg_loader_defs.svh"

module cfg_loader_top #(
    parameter int unsigned SLOT_BASE = 16
) (
    input  logic                        ap_clk,
    input  logic                        arst_n,
    input  logic                        word_valid,
    input  cfg_loader_pkg::mem_cmd_e    word_cmd,
    input  logic [`CFG_ADDR_W-1:0]      word_offset,
    input  logic [`CFG_SHIFT_W-1:0]     word_shift,
    input  logic [`CFG_DATA_W-1:0]      word_data,
    input  logic                        cfg_pop,
    output logic                        cfg_valid,
    output cfg_loader_pkg::cfg_record_t cfg_record,
    output logic                        cfg_full,
    output logic                        cfg_empty
);

    // Accepted program words
    logic                        acc_valid;
    cfg_loader_pkg::slot_t       acc_slot;
    logic [`CFG_DATA_W-1:0]      acc_data;

    // Completed record toward the FIFO
    logic                        rec_done;
    cfg_loader_pkg::cfg_record_t rec_data;

    prog_word_filter #(
        .SLOT_BASE (SLOT_BASE)
    ) u_filter (
        .ap_clk      (ap_clk),
        .arst_n      (arst_n),
        .word_valid  (word_valid),
        .word_cmd    (word_cmd),
        .word_offset (word_offset),
        .word_shift  (word_shift),
        .word_data   (word_data),
        .acc_valid   (acc_valid),
        .acc_slot    (acc_slot),
        .acc_data    (acc_data)
    );

    cfg_slot_sequencer u_sequencer (
        .ap_clk    (ap_clk),
        .arst_n    (arst_n),
        .acc_valid (acc_valid),
        .acc_slot  (acc_slot),
        .rec_done  (rec_done)
    );

    cfg_field_assembler u_assembler (
        .ap_clk    (ap_clk),
        .arst_n    (arst_n),
        .acc_valid (acc_valid),
        .acc_slot  (acc_slot),
        .acc_data  (acc_data),
        .rec_data  (rec_data)
    );

    cfg_record_fifo u_fifo (
        .ap_clk     (ap_clk),
        .arst_n     (arst_n),
        .rec_done   (rec_done),
        .rec_data   (rec_data),
        .cfg_pop    (cfg_pop),
        .cfg_valid  (cfg_valid),
        .cfg_record (cfg_record),
        .cfg_full   (cfg_full),
        .cfg_empty  (cfg_empty)
    );

endmodule

`default_nettype wire

// ==== verilog/cfg_record_fifo.sv ====
// -------------------------------------------------------------------------
// Synchronous record FIFO with pop strobe and registered output
// -------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "cfg_loader_defs.svh"

module cfg_record_fifo (
    input  logic                        ap_clk,
    input  logic                        arst_n,
    input  logic                        rec_done,
    input  cfg_loader_pkg::cfg_record_t rec_data,
    input  logic                        cfg_pop,
    output logic                        cfg_valid,
    output cfg_loader_pkg::cfg_record_t cfg_record,
    output logic                        cfg_full,
    output logic                        cfg_empty
);

    localparam int DEPTH = `CFG_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    cfg_loader_pkg::cfg_record_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    // Push while full drops the record
    assign wr_en = rec_done & ~cfg_full;
    assign rd_en = cfg_pop & ~cfg_empty;

    assign cfg_full  = (count == CNT_W'(DEPTH));
    assign cfg_empty = (count == '0);

    // -------------------------------------------------------------------------
    // Pointers and fill level
    // -------------------------------------------------------------------------
    always_ff @(posedge ap_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= rec_data;
        end
    end

    // Output register, record stays after the valid pulse
    always_ff @(posedge ap_clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg_valid  <= 1'b0;
            cfg_record <= '0;
        end else begin
            cfg_valid <= rd_en;
            if (rd_en) begin
                cfg_record <= mem[rd_ptr];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cfg_field_assembler.sv ====
// -------------------------------------------------------------------------
// Configuration record register, one field group written per slot
// -------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "cfg_loader_defs.svh"

module cfg_field_assembler (
    input  logic                        ap_clk,
    input  logic                        arst_n,
    input  logic                        acc_valid,
    input  cfg_loader_pkg::slot_t       acc_slot,
    input  logic [`CFG_DATA_W-1:0]      acc_data,
    output cfg_loader_pkg::cfg_record_t rec_data
);

    localparam int RW = `CFG_ROUTE_ID_W;
    localparam int NF = `CFG_NUM_FIELDS;

    // -------------------------------------------------------------------------
    // Field capture
    // -------------------------------------------------------------------------
    always_ff @(posedge ap_clk or negedge arst_n) begin
        if (!arst_n) begin
            rec_data <= '0;
        end else if (acc_valid) begin
            case (acc_slot)
                4'd0: begin
                    rec_data.filter_op <= cfg_loader_pkg::filter_op_e'(acc_data[2:0]);
                end
                4'd1: begin
                    rec_data.filter_mask <= acc_data[NF-1:0];
                end
                4'd2: begin
                    rec_data.const_mask <= acc_data[NF-1:0];
                end
                4'd3: begin
                    rec_data.const_value <= acc_data;
                end
                4'd4: begin
                    rec_data.ops_mask <= acc_data[NF*NF-1:0];
                end
                4'd5: begin
                    rec_data.flags.break_flag       <= acc_data[0];
                    rec_data.flags.break_pass       <= acc_data[1];
                    rec_data.flags.filter_post      <= acc_data[2];
                    rec_data.flags.filter_pass      <= acc_data[3];
                    rec_data.flags.continue_flag    <= acc_data[4];
                    rec_data.flags.ternary_flag     <= acc_data[5];
                    rec_data.flags.conditional_flag <= acc_data[6];
                end
                4'd6: begin
                    rec_data.route_if.cu     <= acc_data[RW-1:0];
                    rec_data.route_if.bundle <= acc_data[2*RW-1:RW];
                    rec_data.route_if.lane   <= acc_data[3*RW-1:2*RW];
                end
                4'd7: begin
                    rec_data.route_else.cu     <= acc_data[RW-1:0];
                    rec_data.route_else.bundle <= acc_data[2*RW-1:RW];
                    rec_data.route_else.lane   <= acc_data[3*RW-1:2*RW];
                end
                4'd8: begin
                    // Engine and module ids of both routes share one word
                    rec_data.route_if.engine      <= acc_data[RW-1:0];
                    rec_data.route_if.module_id   <= acc_data[2*RW-1:RW];
                    rec_data.route_else.engine    <= acc_data[3*RW-1:2*RW];
                    rec_data.route_else.module_id <= acc_data[4*RW-1:3*RW];
                end
                default: begin
                    // Slots 9 to 15 carry no field
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cfg_slot_sequencer.sv ====
// -------------------------------------------------------------------------
// One-hot slot sequence tracker with record completion pulse
// -------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "cfg_loader_defs.svh"

module cfg_slot_sequencer (
    input  logic                  ap_clk,
    input  logic                  arst_n,
    input  logic                  acc_valid,
    input  cfg_loader_pkg::slot_t acc_slot,
    output logic                  rec_done
);

    // Bit k set means k+1 words of the sequence have been taken
    localparam int LAST = `CFG_SLOT_COUNT - 1;

    logic [`CFG_SLOT_COUNT-1:0] seq_pos;
    logic                       seq_idle;
    logic                       start_hit;

    // The completed state lasts one cycle and already counts as idle
    assign seq_idle  = ~|seq_pos[LAST-1:0];
    assign start_hit = (acc_slot == '0);
    assign rec_done  = seq_pos[LAST];

    // -------------------------------------------------------------------------
    // Sequence state
    // -------------------------------------------------------------------------
    always_ff @(posedge ap_clk or negedge arst_n) begin
        if (!arst_n) begin
            seq_pos <= '0;
        end else begin
            if (acc_valid) begin
                if (!seq_idle) begin
                    // 16th word lands on the last bit
                    seq_pos <= seq_pos << 1;
                end else if (start_hit) begin
                    // Only slot 0 opens a sequence
                    seq_pos <= `CFG_SLOT_COUNT'(1);
                end else begin
                    seq_pos <= '0;
                end
            end else if (rec_done) begin
                seq_pos <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/prog_word_filter.sv ====
// -------------------------------------------------------------------------
// Program word filter: command and engine window test, slot extraction
// -------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "cfg_loader_defs.svh"

module prog_word_filter #(
    parameter int unsigned SLOT_BASE = 16
) (
    input  logic                         ap_clk,
    input  logic                         arst_n,
    input  logic                         word_valid,
    input  cfg_loader_pkg::mem_cmd_e     word_cmd,
    input  logic [`CFG_ADDR_W-1:0]       word_offset,
    input  logic [`CFG_SHIFT_W-1:0]      word_shift,
    input  logic [`CFG_DATA_W-1:0]       word_data,
    output logic                         acc_valid,
    output cfg_loader_pkg::slot_t        acc_slot,
    output logic [`CFG_DATA_W-1:0]       acc_data
);

    // Window bounds as word indices
    localparam logic [`CFG_ADDR_W-1:0] WIN_LO = `CFG_ADDR_W'(SLOT_BASE);
    localparam logic [`CFG_ADDR_W-1:0] WIN_HI = `CFG_ADDR_W'(SLOT_BASE + `CFG_SLOT_COUNT);

    logic [`CFG_ADDR_W-1:0] word_index;
    logic [`CFG_ADDR_W-1:0] word_rel;
    logic                   is_program;
    logic                   in_window;

    // Byte offset to word index
    assign word_index = word_offset >> word_shift;
    assign word_rel   = word_index - WIN_LO;

    assign is_program = (word_cmd == cfg_loader_pkg::CMD_MEM_PROGRAM);
    assign in_window  = (word_index >= WIN_LO) && (word_index < WIN_HI);

    // -------------------------------------------------------------------------
    // Registered acceptance
    // -------------------------------------------------------------------------
    always_ff @(posedge ap_clk or negedge arst_n) begin
        if (!arst_n) begin
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= word_valid & is_program & in_window;
        end
    end

    // Slot and data only matter while acc_valid is high
    always_ff @(posedge ap_clk) begin
        acc_slot <= word_rel[`CFG_SLOT_W-1:0];
        acc_data <= word_data;
    end

endmodule

`default_nettype wire

// ==== verilog/cfg_loader_pkg.sv ====
// -------------------------------------------------------------------------
// Command and filter operation encodings, route, flag and record types
// -------------------------------------------------------------------------

`default_nettype none

`include "cfg_loader_defs.svh"

package cfg_loader_pkg;

    // Memory response command
    typedef enum logic [1:0] {
        CMD_INVALID     = 2'd0,
        CMD_MEM_PROGRAM = 2'd1,
        CMD_MEM_READ    = 2'd2
    } mem_cmd_e;

    // Comparison applied by the filter engine
    typedef enum logic [2:0] {
        FILTER_EQ   = 3'd0,
        FILTER_GT   = 3'd1,
        FILTER_LT   = 3'd2,
        FILTER_GE   = 3'd3,
        FILTER_LE   = 3'd4,
        FILTER_AND  = 3'd5,
        FILTER_NE   = 3'd6,
        FILTER_PASS = 3'd7
    } filter_op_e;

    typedef logic [`CFG_SLOT_W-1:0] slot_t;

    // Destination of a packet, module is a keyword hence module_id
    typedef struct packed {
        logic [`CFG_ROUTE_ID_W-1:0] cu;
        logic [`CFG_ROUTE_ID_W-1:0] bundle;
        logic [`CFG_ROUTE_ID_W-1:0] lane;
        logic [`CFG_ROUTE_ID_W-1:0] engine;
        logic [`CFG_ROUTE_ID_W-1:0] module_id;
    } route_id_t;

    typedef struct packed {
        logic break_flag;
        logic break_pass;
        logic filter_post;
        logic filter_pass;
        logic continue_flag;
        logic ternary_flag;
        logic conditional_flag;
    } cfg_flags_t;

    // -------------------------------------------------------------------------
    // One complete engine configuration
    // -------------------------------------------------------------------------
    typedef struct packed {
        filter_op_e                                   filter_op;
        logic [`CFG_NUM_FIELDS-1:0]                   filter_mask;
        logic [`CFG_NUM_FIELDS-1:0]                   const_mask;
        logic [`CFG_DATA_W-1:0]                       const_value;
        logic [`CFG_NUM_FIELDS*`CFG_NUM_FIELDS-1:0]   ops_mask;
        cfg_flags_t                                   flags;
        route_id_t                                    route_if;
        route_id_t                                    route_else;
    } cfg_record_t;

endpackage

`default_nettype wire

// ==== verilog/cfg_loader_defs.svh ====
// -------------------------------------------------------------------------
// Widths, record window size and FIFO depth for the configuration loader
// -------------------------------------------------------------------------

`ifndef CFG_LOADER_DEFS_SVH
`define CFG_LOADER_DEFS_SVH

// Memory response word
`define CFG_DATA_W      32
`define CFG_ADDR_W      32
`define CFG_SHIFT_W     5

// Program window of one engine
`define CFG_SLOT_COUNT  16
`define CFG_SLOT_W      4

// Engine data fields, sizes the filter, const and ops masks
`define CFG_NUM_FIELDS  4

// Each route identifier field
`define CFG_ROUTE_ID_W  4

// Records buffered ahead of the consumer
`define CFG_FIFO_DEPTH  16

`endif
